//--- filelist.f
hdl/rvPkg.sv
hdl/Alu.sv
hdl/ImmGen.sv
hdl/RegFile.sv
hdl/DataMem.sv
hdl/ProgramCounter.sv
hdl/Execute.sv
hdl/Core.sv
tb/tbClock.sv
tb/tbCore.sv

//--- hdl/Alu.sv
`timescale 1ns/1ps

module Alu
	import rvPkg::*;
(
	input logic [3:0] aluOp,
	input logic [DataWidth-1:0] aluX,
	input logic [DataWidth-1:0] aluY,
	output logic [DataWidth-1:0] aluResult
);

	logic [4:0] shamt;
	logic lessSigned;
	logic lessUnsigned;

	assign shamt = aluY[4:0]; // only the low five bits shift
	assign lessSigned = $signed(aluX) < $signed(aluY);
	assign lessUnsigned = aluX < aluY;

	always_comb
	begin
		case (aluOp)
			AluAdd: aluResult = aluX + aluY;
			AluSub: aluResult = aluX - aluY;
			AluSll: aluResult = aluX << shamt;
			AluSlt: aluResult = {{(DataWidth-1){1'b0}}, lessSigned};
			AluSltu: aluResult = {{(DataWidth-1){1'b0}}, lessUnsigned};
			AluXor: aluResult = aluX ^ aluY;
			AluSrl: aluResult = aluX >> shamt;
			AluSra: aluResult = $unsigned($signed(aluX) >>> shamt);
			AluOr: aluResult = aluX | aluY;
			AluAnd: aluResult = aluX & aluY;
			// compares for branches, result in bit 0
			AluEq: aluResult = {{(DataWidth-1){1'b0}}, aluX == aluY};
			AluNe: aluResult = {{(DataWidth-1){1'b0}}, aluX != aluY};
			AluGe: aluResult = {{(DataWidth-1){1'b0}}, !lessSigned};
			AluGeu: aluResult = {{(DataWidth-1){1'b0}}, !lessUnsigned};
			default: aluResult = '0;
		endcase
	end

endmodule

//--- hdl/Core.sv
`timescale 1ns/1ps

module Core
	import rvPkg::*;
(
	input logic clk,
	input logic reset,
	input logic instrValid,
	input instrT instr,
	output logic [AddrWidth-1:0] pc,
	output logic commitValid,
	output logic [4:0] commitRd,
	output logic [DataWidth-1:0] commitData,
	output logic commitWrite
);

	logic [DataWidth-1:0] regReadData0;
	logic [DataWidth-1:0] regReadData1;
	logic [DataWidth-1:0] imm;
	logic [3:0] aluOp;
	logic [DataWidth-1:0] aluX;
	logic [DataWidth-1:0] aluY;
	logic [DataWidth-1:0] aluResult;
	logic [AddrWidth-1:0] memAddr;
	logic [DataWidth-1:0] memWriteData;
	logic [DataWidth-1:0] memReadData;
	logic [3:0] memByteEn;
	logic memWriteEnable;
	logic regWriteEnable;
	logic [DataWidth-1:0] regWriteData;
	logic [1:0] pcOp;
	logic [AddrWidth-1:0] pcTarget;

	ImmGen ImmGen_i (.instr(instr), .imm(imm));

	RegFile RegFile_i (
		.clk(clk), .reset(reset),
		.rs1(instr.r.rs1), .rs2(instr.r.rs2),
		.readData0(regReadData0), .readData1(regReadData1),
		.writeEnable(regWriteEnable), .rd(instr.r.rd), .writeData(regWriteData)
	);

	Alu Alu_i (.aluOp(aluOp), .aluX(aluX), .aluY(aluY), .aluResult(aluResult));

	DataMem DataMem_i (
		.clk(clk), .reset(reset), .memAddr(memAddr), .memReadData(memReadData),
		.memWriteEnable(memWriteEnable), .memByteEn(memByteEn), .memWriteData(memWriteData)
	);

	ProgramCounter ProgramCounter_i (
		.clk(clk), .reset(reset), .advance(instrValid), .pcOp(pcOp),
		.pcOffset(imm), .pcTarget(pcTarget), .pc(pc)
	);

	Execute Execute_i (
		.instrValid(instrValid), .instr(instr),
		.regReadData0(regReadData0), .regReadData1(regReadData1), .imm(imm), .pc(pc),
		.aluOp(aluOp), .aluX(aluX), .aluY(aluY), .aluResult(aluResult),
		.memAddr(memAddr), .memWriteData(memWriteData), .memByteEn(memByteEn),
		.memWriteEnable(memWriteEnable), .memReadData(memReadData),
		.regWriteEnable(regWriteEnable), .regWriteData(regWriteData),
		.pcOp(pcOp), .pcTarget(pcTarget)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			commitValid <= 1'b0;
			commitWrite <= 1'b0;
		end
		else
		begin
			commitValid <= instrValid; // one cycle after the strobe
			commitWrite <= regWriteEnable;
		end
	end

	always_ff @(posedge clk)
	begin
		commitRd <= instr.r.rd;
		commitData <= regWriteData;
	end

endmodule

//--- hdl/DataMem.sv
`timescale 1ns/1ps

module DataMem
	import rvPkg::*;
(
	input logic clk,
	input logic reset,
	input logic [AddrWidth-1:0] memAddr,
	output logic [DataWidth-1:0] memReadData,
	input logic memWriteEnable,
	input logic [3:0] memByteEn,
	input logic [DataWidth-1:0] memWriteData
);

	localparam int IndexBits = $clog2(MemWords);

	logic [DataWidth-1:0] mem [MemWords];
	logic [IndexBits-1:0] wordIndex;

	// upper address bits are dropped, so addresses wrap
	assign wordIndex = memAddr[IndexBits+1:2];
	assign memReadData = mem[wordIndex]; // whole word, lanes picked by Execute

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int k = 0; k < MemWords; k++)
				mem[k] <= '0;
		end
		else if (memWriteEnable)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (memByteEn[b])
					mem[wordIndex][8*b +: 8] <= memWriteData[8*b +: 8];
			end
		end
	end

endmodule

//--- hdl/Execute.sv
`timescale 1ns/1ps

module Execute
	import rvPkg::*;
(
	input logic instrValid,
	input instrT instr,
	input logic [DataWidth-1:0] regReadData0,
	input logic [DataWidth-1:0] regReadData1,
	input logic [DataWidth-1:0] imm,
	input logic [AddrWidth-1:0] pc,
	output logic [3:0] aluOp,
	output logic [DataWidth-1:0] aluX,
	output logic [DataWidth-1:0] aluY,
	input logic [DataWidth-1:0] aluResult,
	output logic [AddrWidth-1:0] memAddr,
	output logic [DataWidth-1:0] memWriteData,
	output logic [3:0] memByteEn,
	output logic memWriteEnable,
	input logic [DataWidth-1:0] memReadData,
	output logic regWriteEnable,
	output logic [DataWidth-1:0] regWriteData,
	output logic [1:0] pcOp,
	output logic [AddrWidth-1:0] pcTarget
);

	logic writeReg;
	logic writeMem;
	logic [7:0] loadByte;
	logic [15:0] loadHalf;
	logic [AddrWidth-1:0] linkAddr;

	// shared by R and I arithmetic; bit 30 picks sub and sra
	function automatic logic [3:0] arithOp(input logic [2:0] funct3, input logic subSel,
		input logic sraSel);
		case (funct3)
			3'd0: arithOp = subSel ? AluSub : AluAdd;
			3'd1: arithOp = AluSll;
			3'd2: arithOp = AluSlt;
			3'd3: arithOp = AluSltu;
			3'd4: arithOp = AluXor;
			3'd5: arithOp = sraSel ? AluSra : AluSrl;
			3'd6: arithOp = AluOr;
			default: arithOp = AluAnd;
		endcase
	endfunction

	assign memAddr = aluResult; // loads and stores use rs1 + imm
	assign pcTarget = aluResult;
	assign linkAddr = pc + 32'd4;
	assign loadByte = memReadData[{aluResult[1:0], 3'b000} +: 8];
	assign loadHalf = aluResult[1] ? memReadData[31:16] : memReadData[15:0];

	// state only changes on a strobe; x0 never counts as written
	assign regWriteEnable = instrValid && writeReg && instr.r.rd != 5'd0;
	assign memWriteEnable = instrValid && writeMem;

	always_comb
	begin
		aluOp = AluAdd;
		aluX = regReadData0;
		aluY = imm;
		memWriteData = regReadData1;
		memByteEn = 4'b0000;
		writeMem = 1'b0;
		writeReg = 1'b0;
		regWriteData = aluResult;
		pcOp = PcAdd4;
		case (instr.r.opcode)
			OpR:
			begin
				aluOp = arithOp(instr.r.funct3, instr.r.funct7[5], instr.r.funct7[5]);
				aluY = regReadData1;
				writeReg = 1'b1;
			end
			OpI:
			begin
				aluOp = arithOp(instr.i.funct3, 1'b0, instr.r.funct7[5]); // addi has no subi
				writeReg = 1'b1;
			end
			OpLoad:
			begin
				writeReg = 1'b1;
				case (instr.i.funct3)
					3'd0: regWriteData = {{24{loadByte[7]}}, loadByte}; // lb
					3'd1: regWriteData = {{16{loadHalf[15]}}, loadHalf}; // lh
					3'd4: regWriteData = {24'b0, loadByte}; // lbu
					3'd5: regWriteData = {16'b0, loadHalf}; // lhu
					default: regWriteData = memReadData; // lw
				endcase
			end
			OpStore:
			begin
				writeMem = 1'b1;
				case (instr.s.funct3)
					3'd0: // sb, one lane
					begin
						memWriteData = {4{regReadData1[7:0]}};
						memByteEn = 4'b0001 << aluResult[1:0];
					end
					3'd1: // sh
					begin
						memWriteData = {2{regReadData1[15:0]}};
						memByteEn = aluResult[1] ? 4'b1100 : 4'b0011;
					end
					default: memByteEn = 4'b1111; // sw
				endcase
			end
			OpBranch:
			begin
				aluY = regReadData1;
				case (instr.s.funct3)
					3'd1: aluOp = AluNe;
					3'd4: aluOp = AluSlt;
					3'd5: aluOp = AluGe;
					3'd6: aluOp = AluSltu;
					3'd7: aluOp = AluGeu;
					default: aluOp = AluEq; // beq
				endcase
				pcOp = aluResult[0] ? PcAddImm : PcAdd4;
			end
			OpJal:
			begin
				aluX = pc;
				pcOp = PcSet;
				regWriteData = linkAddr;
				writeReg = 1'b1;
			end
			OpJalr:
			begin
				pcOp = PcSet; // bit 0 cleared in ProgramCounter
				regWriteData = linkAddr;
				writeReg = 1'b1;
			end
			OpLui:
			begin
				regWriteData = imm;
				writeReg = 1'b1;
			end
			OpAuipc:
			begin
				aluX = pc;
				writeReg = 1'b1;
			end
			default: pcOp = PcAdd4; // unsupported, just step
		endcase
	end

endmodule

//--- hdl/ImmGen.sv
`timescale 1ns/1ps

module ImmGen
	import rvPkg::*;
(
	input instrT instr,
	output logic [DataWidth-1:0] imm
);

	always_comb
	begin
		case (instr.r.opcode)
			OpI, OpLoad, OpJalr:
				imm = {{20{instr.i.imm[11]}}, instr.i.imm};
			OpStore:
				imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
			OpBranch: // imm[12|10:5] and imm[4:1|11]
			begin
				imm = {{19{instr.s.immHi[6]}}, instr.s.immHi[6], instr.s.immLo[0],
					instr.s.immHi[5:0], instr.s.immLo[4:1], 1'b0};
			end
			OpJal: // imm[20|10:1|11|19:12]
			begin
				imm = {{11{instr.u.imm[19]}}, instr.u.imm[19], instr.u.imm[7:0],
					instr.u.imm[8], instr.u.imm[18:9], 1'b0};
			end
			OpLui, OpAuipc:
				imm = {instr.u.imm, 12'b0}; // upper 20 bits
			default:
				imm = '0;
		endcase
	end

endmodule

//--- hdl/ProgramCounter.sv
`timescale 1ns/1ps

module ProgramCounter
	import rvPkg::*;
(
	input logic clk,
	input logic reset,
	input logic advance,
	input logic [1:0] pcOp,
	input logic [DataWidth-1:0] pcOffset,
	input logic [AddrWidth-1:0] pcTarget,
	output logic [AddrWidth-1:0] pc
);

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= '0;
		else if (advance) // one step per strobe
		begin
			case (pcOp)
				PcAddImm: pc <= pc + pcOffset;
				PcSet: pc <= {pcTarget[AddrWidth-1:1], 1'b0}; // jalr lsb cleared
				default: pc <= pc + 32'd4;
			endcase
		end
	end

endmodule

//--- hdl/RegFile.sv
`timescale 1ns/1ps

module RegFile
	import rvPkg::*;
(
	input logic clk,
	input logic reset,
	input logic [4:0] rs1,
	input logic [4:0] rs2,
	output logic [DataWidth-1:0] readData0,
	output logic [DataWidth-1:0] readData1,
	input logic writeEnable,
	input logic [4:0] rd,
	input logic [DataWidth-1:0] writeData
);

	logic [DataWidth-1:0] regs [32];

	// x0 always reads zero
	assign readData0 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign readData1 = (rs2 == 5'd0) ? '0 : regs[rs2];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int k = 0; k < 32; k++)
				regs[k] <= '0;
		end
		else if (writeEnable && rd != 5'd0)
			regs[rd] <= writeData;
	end

endmodule

//--- hdl/rvPkg.sv
package rvPkg;

	localparam int DataWidth = 32;
	localparam int AddrWidth = 32;
	localparam int MemWords = 256; // data memory depth in words

	localparam logic [6:0] OpR = 7'b0110011;
	localparam logic [6:0] OpI = 7'b0010011;
	localparam logic [6:0] OpLoad = 7'b0000011;
	localparam logic [6:0] OpStore = 7'b0100011;
	localparam logic [6:0] OpBranch = 7'b1100011;
	localparam logic [6:0] OpJal = 7'b1101111;
	localparam logic [6:0] OpJalr = 7'b1100111;
	localparam logic [6:0] OpLui = 7'b0110111;
	localparam logic [6:0] OpAuipc = 7'b0010111;

	localparam logic [3:0] AluAdd = 4'd0;
	localparam logic [3:0] AluSub = 4'd1;
	localparam logic [3:0] AluSll = 4'd2;
	localparam logic [3:0] AluSlt = 4'd3;
	localparam logic [3:0] AluSltu = 4'd4;
	localparam logic [3:0] AluXor = 4'd5;
	localparam logic [3:0] AluSrl = 4'd6;
	localparam logic [3:0] AluSra = 4'd7;
	localparam logic [3:0] AluOr = 4'd8;
	localparam logic [3:0] AluAnd = 4'd9;
	localparam logic [3:0] AluEq = 4'd10;
	localparam logic [3:0] AluNe = 4'd11;
	localparam logic [3:0] AluGe = 4'd12; // signed
	localparam logic [3:0] AluGeu = 4'd13;

	localparam logic [1:0] PcAdd4 = 2'd0;
	localparam logic [1:0] PcAddImm = 2'd1; // branch taken
	localparam logic [1:0] PcSet = 2'd2; // jal and jalr target

	// one instruction word seen through each encoding format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i;
		struct packed {
			logic [6:0] immHi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] immLo;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic [19:0] imm;
			logic [4:0] rd;
			logic [6:0] opcode;
		} u;
	} instrT;

endpackage

//--- tb/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		repeat (4) @(posedge clk); // four reset edges
		reset <= 1'b0;
	end

	always #5 clk = ~clk; // 10 ns period

endmodule

//--- tb/tbCore.sv
`timescale 1ns/1ps

module tbCore
	import rvPkg::*;
();

	logic clk;
	logic reset;
	logic instrValid;
	instrT instr;
	logic [AddrWidth-1:0] pc;
	logic commitValid;
	logic [4:0] commitRd;
	logic [DataWidth-1:0] commitData;
	logic commitWrite;

	integer seed;
	integer cycle = 0;
	logic [31:0] regs [32]; // architectural model
	logic [31:0] mem [MemWords];
	logic [31:0] modelPc;
	logic [4:0] expRd [$];
	logic [31:0] expData [$];
	logic expWrite [$];
	logic [31:0] expPc [$];
	integer expCycle [$];

	tbClock tbClock_i (.clk(clk), .reset(reset));

	Core Core_i (
		.clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr), .pc(pc),
		.commitValid(commitValid), .commitRd(commitRd), .commitData(commitData),
		.commitWrite(commitWrite)
	);

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic stopWithFail();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("FAILED %s: got %h, expected %h", name, actual, expected);
			stopWithFail();
		end
	endtask

	function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: arith = alt ? a - b : a + b;
			3'd1: arith = a << b[4:0];
			3'd2: arith = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: arith = (a < b) ? 32'd1 : 32'd0;
			3'd4: arith = a ^ b;
			3'd5: arith = (alt && a[31]) ? ~(~a >> b[4:0]) : a >> b[4:0]; // sra fills ones
			3'd6: arith = a | b;
			default: arith = a & b;
		endcase
	endfunction

	function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'd0: branchTaken = a == b;
			3'd1: branchTaken = a != b;
			3'd4: branchTaken = $signed(a) < $signed(b);
			3'd5: branchTaken = $signed(a) >= $signed(b);
			3'd6: branchTaken = a < b;
			default: branchTaken = a >= b;
		endcase
	endfunction

	// random but legal encodings for each instruction class
	function automatic logic [31:0] makeInstr(input int kind, input logic [31:0] r);
		logic [2:0] f3;
		logic [2:0] lf3;
		logic [2:0] bf3;
		logic [1:0] sf3;
		logic [4:0] base;
		f3 = r[14:12];
		lf3 = (f3 == 3'd3) ? 3'd2 : (f3[2:1] == 2'b11) ? {2'b10, f3[0]} : f3;
		bf3 = (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3; // no funct3 2 or 3
		sf3 = (f3[1:0] == 2'b11) ? 2'b10 : f3[1:0];
		base = r[29] ? r[19:15] : 5'd0; // x0 base keeps addresses near zero
		case (kind)
			0: makeInstr = {1'b0, r[30] && (f3 == 3'd0 || f3 == 3'd5), 5'b0, r[24:7], OpR};
			1: makeInstr = (f3[1:0] == 2'b01) ? {1'b0, f3[2] & r[30], 5'b0, r[24:7], OpI}
				: {r[31:7], OpI};
			2: makeInstr = {r[31:20], base, 1'b0, sf3, r[11:7], OpStore};
			3: makeInstr = {r[31:20], base, lf3, r[11:7], OpLoad};
			4: makeInstr = {r[31:15], bf3, r[11:7], OpBranch};
			5: makeInstr = {r[31:7], OpJal};
			6: makeInstr = {r[31:15], 3'b000, r[11:7], OpJalr};
			7: makeInstr = {r[31:7], r[0] ? OpLui : OpAuipc};
			default: makeInstr = {r[31:7], 7'b0001111}; // fence is not supported
		endcase
	endfunction

	// drive one strobe and apply the instruction to the model
	task automatic issue(input logic [31:0] w);
		logic [6:0] op;
		logic [2:0] f3;
		logic [4:0] rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] addr;
		logic [31:0] word;
		logic [7:0] byteVal;
		logic [15:0] halfVal;
		logic [31:0] result;
		logic [31:0] nextPc;
		logic wr;
		@(posedge clk);
		op = w[6:0];
		f3 = w[14:12];
		rd = w[11:7];
		a = regs[w[19:15]];
		b = regs[w[24:20]];
		immI = {{20{w[31]}}, w[31:20]};
		immS = {{20{w[31]}}, w[31:25], w[11:7]};
		addr = a + ((op == OpStore) ? immS : immI);
		word = mem[addr[9:2]]; // word index wraps
		byteVal = word[8*addr[1:0] +: 8];
		halfVal = addr[1] ? word[31:16] : word[15:0];
		result = 32'h0;
		nextPc = modelPc + 32'd4;
		wr = 1'b0;
		case (op)
			OpR:
			begin
				result = arith(f3, w[30], a, b);
				wr = 1'b1;
			end
			OpI:
			begin
				result = arith(f3, w[30] && f3 == 3'd5, a, immI);
				wr = 1'b1;
			end
			OpLoad:
			begin
				wr = 1'b1;
				case (f3)
					3'd0: result = {{24{byteVal[7]}}, byteVal};
					3'd1: result = {{16{halfVal[15]}}, halfVal};
					3'd4: result = {24'h0, byteVal};
					3'd5: result = {16'h0, halfVal};
					default: result = word;
				endcase
			end
			OpStore:
			begin
				case (f3)
					3'd0: word[8*addr[1:0] +: 8] = b[7:0];
					3'd1: word[16*addr[1] +: 16] = b[15:0];
					default: word = b;
				endcase
				mem[addr[9:2]] = word;
			end
			OpBranch:
			begin
				if (branchTaken(f3, a, b))
					nextPc = modelPc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			end
			OpJal:
			begin
				result = modelPc + 32'd4;
				wr = 1'b1;
				nextPc = modelPc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			end
			OpJalr:
			begin
				result = modelPc + 32'd4;
				wr = 1'b1;
				nextPc = (a + immI) & ~32'h1;
			end
			OpLui:
			begin
				result = {w[31:12], 12'h0};
				wr = 1'b1;
			end
			OpAuipc:
			begin
				result = modelPc + {w[31:12], 12'h0};
				wr = 1'b1;
			end
			default: wr = 1'b0;
		endcase
		if (rd == 5'd0)
			wr = 1'b0; // x0 stays zero
		if (wr)
			regs[rd] = result;
		modelPc = nextPc;
		expRd.push_back(rd);
		expData.push_back(result);
		expWrite.push_back(wr);
		expPc.push_back(nextPc);
		expCycle.push_back(cycle + 2); // sampled one cycle after the strobe edge
		instrValid <= 1'b1;
		instr <= w;
	endtask

	task automatic idle(input int count);
		repeat (count)
		begin
			@(posedge clk);
			instrValid <= 1'b0;
		end
	endtask

	task automatic waitForCommit();
		int n;
		n = 0;
		while (commitValid !== 1'b1 && n < 20)
		begin
			@(posedge clk);
			n++;
		end
		if (commitValid !== 1'b1)
		begin
			$display("ERROR: commit never arrived within 20 cycles");
			stopWithFail();
		end
	endtask

	task automatic compareCommit();
		logic [4:0] rd;
		logic [31:0] data;
		logic wr;
		logic [31:0] nextPc;
		integer when;
		rd = expRd.pop_front();
		data = expData.pop_front();
		wr = expWrite.pop_front();
		nextPc = expPc.pop_front();
		when = expCycle.pop_front();
		checkValue("commit cycle", cycle, when);
		checkValue("commitWrite", commitWrite, wr);
		checkValue("pc", pc, nextPc);
		if (wr)
		begin
			checkValue("commitRd", commitRd, rd);
			checkValue("commitData", commitData, data);
		end
	endtask

	initial
	begin
		forever
		begin
			@(posedge clk);
			if (expWrite.size() > 0)
			begin
				waitForCommit();
				compareCommit();
			end
			else if (commitValid === 1'b1)
			begin
				$display("ERROR: commit reported with no instruction outstanding");
				stopWithFail();
			end
		end
	end

	initial
	begin
		int n;
		int kind;
		int gap;
		int storeSize;
		int loadF3;
		logic [31:0] r;
		seed = 32'hd865_3ca9;
		instrValid = 1'b0;
		instr = '0;
		modelPc = 32'h0;
		for (int k = 0; k < 32; k++)
			regs[k] = 32'h0;
		for (int k = 0; k < MemWords; k++)
			mem[k] = 32'h0;
		n = 0;
		while (reset !== 1'b0 && n < 10)
		begin
			@(posedge clk);
			n++;
		end
		if (reset !== 1'b0)
		begin
			$display("ERROR: reset was never released");
			stopWithFail();
		end
		checkValue("pc", pc, 32'h0);
		repeat (3) @(posedge clk); // no strobe so no commit expected
		checkValue("commitValid", commitValid, 1'b0);
		for (int k = 0; k < 32; k++)
			issue({12'h000, k[4:0], 3'd0, k[4:0], OpI}); // addi xk, xk, 0
		for (int k = 1; k < 32; k++)
		begin
			r = $random(seed);
			issue({r[31:12], k[4:0], OpLui});
			issue({r[11:0], k[4:0], 3'd0, k[4:0], OpI});
		end
		issue({20'h80000, 5'd1, OpLui}); // x1 most negative
		issue({12'hfff, 5'd0, 3'd0, 5'd2, OpI}); // x2 all ones
		issue({7'h00, 5'd2, 5'd1, 3'd3, 5'd4, OpR}); // sltu
		issue({7'h00, 5'd2, 5'd1, 3'd2, 5'd5, OpR}); // slt
		issue({7'h20, 5'd2, 5'd1, 3'd0, 5'd6, OpR}); // sub
		issue({7'h20, 5'd2, 5'd1, 3'd5, 5'd7, OpR}); // sra by 31
		issue({12'h005, 5'd2, 3'd0, 5'd0, OpI}); // write to x0 is dropped
		issue({12'h000, 5'd0, 3'd0, 5'd8, OpI});
		// store through the large x1 base so the address wraps, then reload the word
		for (int k = 0; k < 24; k++)
		begin
			r = $random(seed);
			issue({r[31:12], 5'd9, OpLui}); // random store data in x9
			issue({r[11:0], 5'd9, 3'd0, 5'd9, OpI});
			r = $random(seed);
			storeSize = k % 3;
			issue({r[31:25], 5'd9, 5'd1, 1'b0, storeSize[1:0], r[11:7], OpStore});
			for (int j = 0; j < 5; j++)
			begin
				loadF3 = (j < 3) ? j : j + 1; // lb lh lw lbu lhu
				issue({r[31:25], r[11:9], r[2*j +: 2], 5'd1, loadF3[2:0], 5'd10, OpLoad});
			end
		end
		for (int k = 0; k < 400; k++)
		begin
			gap = ($random(seed) & 32'h7fff_ffff) % 3;
			kind = ($random(seed) & 32'h7fff_ffff) % 9;
			r = $random(seed);
			idle(gap);
			issue(makeInstr(kind, r));
		end
		idle(1);
		n = 0;
		while (expWrite.size() > 0 && n < 20)
		begin
			@(posedge clk);
			n++;
		end
		if (expWrite.size() > 0)
		begin
			$display("ERROR: commits still outstanding at the end of the run");
			stopWithFail();
		end
		else
		begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule
